//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // --------------------
    // Table geometry
    // --------------------
    localparam int MEM_ADDR_WID = 8;
    localparam int MEM_DATA_WID = 32;
    localparam int MEM_DEPTH    = 2**MEM_ADDR_WID;

    // --------------------
    // Vector types
    // --------------------
    // Table address
    typedef logic [MEM_ADDR_WID-1:0] mem_addr_t;

    // One table entry
    typedef logic [MEM_DATA_WID-1:0] mem_data_t;

    // --------------------
    // Clear sequencer
    // --------------------
    // IDLE_RESET holds while reset is applied, CLEAR walks the table
    typedef enum logic [1:0] {
        IDLE_RESET,
        CLEAR,
        DONE
    } init_state_t;

endpackage : mem_pkg

`default_nettype wire

//--- hdl/mem_reset_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module mem_reset_fsm
    import mem_pkg::*;
#(
    parameter mem_data_t RESET_VAL = '0
) (
    input  wire       rd_clk,
    input  wire       rd_srst_local,
    input  wire       clear,

    // Init write stream into the core
    output logic      init_wr,
    output mem_addr_t init_addr,
    output mem_data_t init_data,

    // Table holds RESET_VAL everywhere
    output logic      init_done
);

    init_state_t state;
    init_state_t state_nxt;
    mem_addr_t   addr_cnt;
    logic        last_addr;

    assign last_addr = (addr_cnt == mem_addr_t'(MEM_DEPTH - 1));

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge rd_clk) begin
        if (rd_srst_local) begin
            state <= IDLE_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE_RESET: state_nxt = CLEAR;
            CLEAR: begin
                if (last_addr) begin
                    state_nxt = DONE;
                end
            end
            DONE:       state_nxt = DONE;
            default:    state_nxt = IDLE_RESET;
        endcase
        // A clear strobe restarts the sweep, even mid-sweep
        if (clear) begin
            state_nxt = CLEAR;
        end
    end

    // --------------------
    // Address counter
    // --------------------
    // Steps once per init write, back to 0 on restart
    always_ff @(posedge rd_clk) begin
        if (rd_srst_local || clear || (state != CLEAR)) begin
            addr_cnt <= '0;
        end else begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // One init write per cycle while sweeping
    assign init_wr   = (state == CLEAR);
    assign init_addr = addr_cnt;
    assign init_data = RESET_VAL;

    // Rises the cycle after the write to the last entry
    assign init_done = (state == DONE);

endmodule : mem_reset_fsm

`default_nettype wire

//--- hdl/mem_wr_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wr_pipe
    import mem_pkg::*;
#(
    parameter int WR_PIPE_STAGES = 2
) (
    input  wire       rd_clk,
    input  wire       rd_srst_local,

    // User write request
    input  wire       wr_req,
    input  mem_addr_t wr_addr,
    input  mem_data_t wr_data,

    // Delayed write toward the core
    output logic      pipe_wr,
    output mem_addr_t pipe_addr,
    output mem_data_t pipe_data
);

    generate
        if (WR_PIPE_STAGES > 0) begin : g_pipe
            logic      wr_p   [WR_PIPE_STAGES];
            mem_addr_t addr_p [WR_PIPE_STAGES];
            mem_data_t data_p [WR_PIPE_STAGES];

            // Strobe chain
            always_ff @(posedge rd_clk) begin
                if (rd_srst_local) begin
                    for (int i = 0; i < WR_PIPE_STAGES; i++) begin
                        wr_p[i] <= 1'b0;
                    end
                end else begin
                    wr_p[0] <= wr_req;
                    for (int i = 1; i < WR_PIPE_STAGES; i++) begin
                        wr_p[i] <= wr_p[i-1];
                    end
                end
            end

            // Address and data follow the strobe stage for stage
            always_ff @(posedge rd_clk) begin
                addr_p[0] <= wr_addr;
                data_p[0] <= wr_data;
                for (int i = 1; i < WR_PIPE_STAGES; i++) begin
                    addr_p[i] <= addr_p[i-1];
                    data_p[i] <= data_p[i-1];
                end
            end

            assign pipe_wr   = wr_p[WR_PIPE_STAGES-1];
            assign pipe_addr = addr_p[WR_PIPE_STAGES-1];
            assign pipe_data = data_p[WR_PIPE_STAGES-1];
        end else begin : g_no_pipe
            // Straight through, written on the request edge
            assign pipe_wr   = wr_req;
            assign pipe_addr = wr_addr;
            assign pipe_data = wr_data;
        end
    endgenerate

endmodule : mem_wr_pipe

`default_nettype wire

//--- hdl/mem_ram_sdp_core.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp_core
    import mem_pkg::*;
#(
    parameter int RD_PIPE_STAGES = 1
) (
    input  wire       rd_clk,
    input  wire       rd_srst_local,

    // Clear sequencer writes
    input  wire       init_wr,
    input  mem_addr_t init_addr,
    input  mem_data_t init_data,
    input  wire       init_done,

    // User writes from the write pipeline
    input  wire       pipe_wr,
    input  mem_addr_t pipe_addr,
    input  mem_data_t pipe_data,

    // Read port
    input  wire       rd_req,
    input  mem_addr_t rd_addr,
    output logic      rd_ack,
    output mem_data_t rd_data
);

    mem_data_t mem_array [MEM_DEPTH];

    // Selected write
    logic      wr_en;
    mem_addr_t wr_addr_sel;
    mem_data_t wr_data_sel;

    // Array read register and output register
    logic      ram_vld;
    mem_data_t ram_q;
    logic      out_vld;
    mem_data_t out_q;

    // --------------------
    // Write side
    // --------------------
    // Init sweep wins, user writes only once the table is cleared
    always_comb begin
        if (init_wr) begin
            wr_en       = 1'b1;
            wr_addr_sel = init_addr;
            wr_data_sel = init_data;
        end else begin
            wr_en       = pipe_wr && init_done;
            wr_addr_sel = pipe_addr;
            wr_data_sel = pipe_data;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem_array[wr_addr_sel] <= wr_data_sel;
        end
    end

    // --------------------
    // Read side
    // --------------------
    // Same-edge read of a written address sees the old entry
    always_ff @(posedge rd_clk) begin
        if (rd_req) begin
            ram_q <= mem_array[rd_addr];
        end
    end

    always_ff @(posedge rd_clk) begin
        if (ram_vld) begin
            out_q <= ram_q;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst_local) begin
            ram_vld <= 1'b0;
            out_vld <= 1'b0;
        end else begin
            ram_vld <= rd_req;
            out_vld <= ram_vld;
        end
    end

    generate
        if (RD_PIPE_STAGES > 0) begin : g_rd_pipe
            logic      pipe_vld [RD_PIPE_STAGES];
            mem_data_t pipe_q   [RD_PIPE_STAGES];

            // Valid chain, one bit per stage
            always_ff @(posedge rd_clk) begin
                if (rd_srst_local) begin
                    for (int i = 0; i < RD_PIPE_STAGES; i++) begin
                        pipe_vld[i] <= 1'b0;
                    end
                end else begin
                    pipe_vld[0] <= out_vld;
                    for (int i = 1; i < RD_PIPE_STAGES; i++) begin
                        pipe_vld[i] <= pipe_vld[i-1];
                    end
                end
            end

            // Each data stage loads only when the stage before holds a read
            always_ff @(posedge rd_clk) begin
                if (out_vld) begin
                    pipe_q[0] <= out_q;
                end
                for (int i = 1; i < RD_PIPE_STAGES; i++) begin
                    if (pipe_vld[i-1]) begin
                        pipe_q[i] <= pipe_q[i-1];
                    end
                end
            end

            assign rd_ack  = pipe_vld[RD_PIPE_STAGES-1];
            assign rd_data = pipe_q[RD_PIPE_STAGES-1];
        end else begin : g_rd_no_pipe
            assign rd_ack  = out_vld;
            assign rd_data = out_q;
        end
    endgenerate

endmodule : mem_ram_sdp_core

`default_nettype wire

//--- hdl/mem_ram_sdp.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp
    import mem_pkg::*;
#(
    parameter int        WR_PIPE_STAGES = 2,
    parameter int        RD_PIPE_STAGES = 1,
    parameter mem_data_t RESET_VAL      = '0
) (
    input  wire       rd_clk,
    input  wire       rd_srst_local,

    // Table clear request
    input  wire       clear,

    // Write port
    input  wire       wr_req,
    input  mem_addr_t wr_addr,
    input  mem_data_t wr_data,

    // Read port
    input  wire       rd_req,
    input  mem_addr_t rd_addr,
    output logic      rd_ack,
    output mem_data_t rd_data,

    output logic      init_done
);

    logic      init_wr;
    mem_addr_t init_addr;
    mem_data_t init_data;

    logic      pipe_wr;
    mem_addr_t pipe_addr;
    mem_data_t pipe_data;

    // --------------------
    // Clear sequencer
    // --------------------
    mem_reset_fsm #(
        .RESET_VAL     (RESET_VAL)
    ) u_reset_fsm (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .clear         (clear),
        .init_wr       (init_wr),
        .init_addr     (init_addr),
        .init_data     (init_data),
        .init_done     (init_done)
    );

    // --------------------
    // User write pipeline
    // --------------------
    mem_wr_pipe #(
        .WR_PIPE_STAGES (WR_PIPE_STAGES)
    ) u_wr_pipe (
        .rd_clk         (rd_clk),
        .rd_srst_local  (rd_srst_local),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .pipe_wr        (pipe_wr),
        .pipe_addr      (pipe_addr),
        .pipe_data      (pipe_data)
    );

    // --------------------
    // Memory core
    // --------------------
    mem_ram_sdp_core #(
        .RD_PIPE_STAGES (RD_PIPE_STAGES)
    ) u_core (
        .rd_clk         (rd_clk),
        .rd_srst_local  (rd_srst_local),
        .init_wr        (init_wr),
        .init_addr      (init_addr),
        .init_data      (init_data),
        .init_done      (init_done),
        .pipe_wr        (pipe_wr),
        .pipe_addr      (pipe_addr),
        .pipe_data      (pipe_data),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_ack         (rd_ack),
        .rd_data        (rd_data)
    );

endmodule : mem_ram_sdp

`default_nettype wire

//--- verif/mem_ram_sdp_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp_checker
    import mem_pkg::*;
#(
    parameter int NAME_W = 128
) (
    input  wire       rd_clk,
    input  wire       rd_srst_local,
    input  wire       rd_req,
    input  wire       rd_ack,
    input  mem_data_t rd_data
);

    // Expected reads in request order
    logic [NAME_W-1:0] name_q [$];
    mem_data_t         exp_q  [$];

    int outstanding = 0;
    int test_errs   = 0;
    int total_errs  = 0;
    int pass_cnt    = 0;
    int fail_cnt    = 0;

    task automatic expect_read(input logic [NAME_W-1:0] name, input mem_data_t exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
    endtask

    task automatic check_value(input logic [NAME_W-1:0] name, input mem_data_t exp,
                               input mem_data_t act);
        if (act !== exp) begin
            $display("ERROR test=%0s expected=%08h actual=%08h", name, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic note_failure(input logic [NAME_W-1:0] name, input string msg);
        $display("Test %0s: %0s", name, msg);
        test_errs++;
        total_errs++;
    endtask

    function automatic int pending_reads();
        return exp_q.size();
    endfunction

    // --------------------
    // Read port monitor
    // --------------------
    always @(posedge rd_clk) begin
        if (!rd_srst_local) begin
            // Ack first, it belongs to an older request
            if (rd_ack) begin
                if ((exp_q.size() == 0) || (outstanding == 0)) begin
                    $display("rd_ack seen with no read outstanding, data %08h", rd_data);
                    test_errs++;
                    total_errs++;
                end else begin
                    outstanding--;
                    check_value(name_q.pop_front(), exp_q.pop_front(), rd_data);
                end
            end
            if (rd_req) begin
                outstanding++;
            end
        end
    end

    task automatic end_test(input logic [NAME_W-1:0] name);
        if (exp_q.size() != 0) begin
            note_failure(name, $sformatf("%0d reads never acknowledged", exp_q.size()));
            name_q.delete();
            exp_q.delete();
            outstanding = 0;
        end
        if (test_errs == 0) begin
            $display("Test %0s: PASS", name);
            pass_cnt++;
        end else begin
            $display("Test %0s: FAIL, %0d errors", name, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    task automatic print_summary();
        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, total_errs);
    endtask

    function automatic bit run_failed();
        return (fail_cnt != 0) || (total_errs != 0) || (pass_cnt == 0);
    endfunction

endmodule : mem_ram_sdp_checker

`default_nettype wire

//--- verif/mem_ram_sdp_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp_tb
    import mem_pkg::*;
();

    localparam mem_data_t TB_RESET_VAL  = 32'h5a5a_c3c3;
    localparam int        NAME_W        = 128;
    localparam int        INIT_WAIT_MAX = 300;
    localparam string     PATTERN_FILE  = "verif/mem_ram_sdp_patterns.txt";

    logic      rd_clk = 1'b0;
    logic      rd_srst_local;
    logic      clear;
    logic      wr_req;
    mem_addr_t wr_addr;
    mem_data_t wr_data;
    logic      rd_req;
    mem_addr_t rd_addr;
    logic      rd_ack;
    mem_data_t rd_data;
    logic      init_done;

    // Pattern file fields
    int                fd;
    int                line_cnt;
    int                n_fields;
    int                wd_cycles = 0;
    logic [8*96-1:0]   line_buf;
    logic [NAME_W-1:0] f_name;
    logic [63:0]       f_op;
    mem_addr_t         f_addr;
    mem_data_t         f_data;
    mem_data_t         f_exp;

    always #20 rd_clk = ~rd_clk;

    mem_ram_sdp #(
        .RESET_VAL     (TB_RESET_VAL)
    ) u_dut (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .clear         (clear),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_ack        (rd_ack),
        .rd_data       (rd_data),
        .init_done     (init_done)
    );

    mem_ram_sdp_checker #(
        .NAME_W        (NAME_W)
    ) u_checker (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .rd_req        (rd_req),
        .rd_ack        (rd_ack),
        .rd_data       (rd_data)
    );

    // Bounded by one full sweep
    task automatic wait_init(input logic [NAME_W-1:0] name);
        int cycles;
        cycles = 0;
        while (!init_done && (cycles < INIT_WAIT_MAX)) begin
            @(negedge rd_clk);
            cycles++;
        end
        if (!init_done) begin
            u_checker.note_failure(name, "init_done did not rise within one sweep");
        end
    endtask

    // In-flight reads return before a test is closed
    task automatic drain_reads();
        int cycles;
        cycles = 0;
        while ((u_checker.pending_reads() != 0) && (cycles < 16)) begin
            @(negedge rd_clk);
            cycles++;
        end
    endtask

    // --------------------
    // One pattern line
    // --------------------
    task automatic run_op();
        @(negedge rd_clk);
        wr_req = 1'b0;
        rd_req = 1'b0;
        clear  = 1'b0;
        case (f_op)
            64'("wr"): begin
                wr_req  = 1'b1;
                wr_addr = f_addr;
                wr_data = f_data;
            end
            64'("rd"): begin
                rd_req  = 1'b1;
                rd_addr = f_addr;
                u_checker.expect_read(f_name, f_exp);
            end
            64'("clr"): begin
                clear = 1'b1;
                @(negedge rd_clk);
                clear = 1'b0;
                // Sweep restarts on the edge that samples the strobe
                u_checker.check_value(f_name, '0, mem_data_t'(init_done));
            end
            64'("wait"): wait_init(f_name);
            64'("idle"): repeat (f_data) @(negedge rd_clk);
            64'("end"): begin
                drain_reads();
                u_checker.end_test(f_name);
            end
            default: u_checker.note_failure(f_name, "unknown opcode in pattern file");
        endcase
    endtask

    initial begin
        rd_srst_local = 1'b1;
        clear         = 1'b0;
        wr_req        = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_req        = 1'b0;
        rd_addr       = '0;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %0s", PATTERN_FILE);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            // Watchdog length follows the pattern count
            line_cnt = 0;
            while ($fgets(line_buf, fd) != 0) begin
                line_cnt++;
            end
            $fclose(fd);
            wd_cycles = line_cnt * 8 + 3 * 300;

            repeat (8) @(posedge rd_clk);
            @(negedge rd_clk);
            rd_srst_local = 1'b0;
            wait_init(NAME_W'("reset"));

            fd = $fopen(PATTERN_FILE, "r");
            while ($fgets(line_buf, fd) != 0) begin
                n_fields = $sscanf(line_buf, "%s %s %h %h %h",
                                   f_name, f_op, f_addr, f_data, f_exp);
                if ((n_fields == 5) && (f_name != NAME_W'("#"))) begin
                    run_op();
                end
            end
            $fclose(fd);

            @(negedge rd_clk);
            wr_req = 1'b0;
            rd_req = 1'b0;
            clear  = 1'b0;
            u_checker.print_summary();
            if (u_checker.run_failed()) begin
                $display("SIMULATION FAILED");
            end else begin
                $display("SIMULATION PASSED");
            end
            $finish;
        end
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge rd_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : mem_ram_sdp_tb

`default_nettype wire

//--- vlog.f
hdl/mem_pkg.sv
hdl/mem_reset_fsm.sv
hdl/mem_wr_pipe.sv
hdl/mem_ram_sdp_core.sv
hdl/mem_ram_sdp.sv
verif/mem_ram_sdp_checker.sv
verif/mem_ram_sdp_tb.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_ram_sdp_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status follows the search for the pass message in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/mem_ram_sdp_patterns.txt
# test        op    addr  data      expect
# op is wr, rd, clr, wait, idle (cycles in data) or end, all values hex
rst_clear     rd    00    00000000  5a5ac3c3
rst_clear     rd    01    00000000  5a5ac3c3
rst_clear     rd    80    00000000  5a5ac3c3
rst_clear     rd    ff    00000000  5a5ac3c3
rst_clear     end   00    00000000  00000000
wr_rd         wr    10    11111111  00000000
wr_rd         wr    30    33333333  00000000
wr_rd         wr    30    3333aaaa  00000000
wr_rd         idle  00    00000004  00000000
wr_rd         rd    10    00000000  11111111
wr_rd         rd    30    00000000  3333aaaa
wr_rd         end   00    00000000  00000000
rd_burst      wr    40    40404040  00000000
rd_burst      wr    41    41414141  00000000
rd_burst      wr    42    42424242  00000000
rd_burst      idle  00    00000004  00000000
rd_burst      rd    42    00000000  42424242
rd_burst      rd    40    00000000  40404040
rd_burst      rd    41    00000000  41414141
rd_burst      end   00    00000000  00000000
sweep_drop    clr   00    00000000  00000000
sweep_drop    wr    02    dead0002  00000000
sweep_drop    wr    fd    dead00fd  00000000
sweep_drop    wait  00    00000000  00000000
sweep_drop    rd    02    00000000  5a5ac3c3
sweep_drop    rd    fd    00000000  5a5ac3c3
sweep_drop    end   00    00000000  00000000
clr_restore   wr    00    c0de0000  00000000
clr_restore   wr    7f    c0de007f  00000000
clr_restore   wr    ff    c0de00ff  00000000
clr_restore   idle  00    00000004  00000000
clr_restore   clr   00    00000000  00000000
clr_restore   wait  00    00000000  00000000
clr_restore   rd    00    00000000  5a5ac3c3
clr_restore   rd    7f    00000000  5a5ac3c3
clr_restore   rd    ff    00000000  5a5ac3c3
clr_restore   end   00    00000000  00000000
wr_resume     wr    77    abcd0077  00000000
wr_resume     idle  00    00000004  00000000
wr_resume     rd    77    00000000  abcd0077
wr_resume     end   00    00000000  00000000
